// File: design/hps_link_pkg.sv
// host link shared definitions
// command codes, bus widths and the word, event and ioctl types
// passed between the framing stage and the decode stages

package hps_link_pkg;

	////////////////////
	// widths

	localparam int WORD_W     = 16;
	// word index within a frame saturates at all ones
	localparam int IDX_W      = 4;
	localparam int NUM_JOY    = 4;
	localparam int JOY_IW     = $clog2(NUM_JOY);
	localparam int IOCTL_AW   = 27;
	// bytes per 16-bit data word
	localparam int IOCTL_STEP = 2;

	////////////////////
	// user-io commands

	localparam logic [WORD_W-1:0] CMD_CFG        = 16'h0001;
	localparam logic [WORD_W-1:0] CMD_JOY0       = 16'h0002;
	localparam logic [WORD_W-1:0] CMD_JOY1       = 16'h0003;
	localparam logic [WORD_W-1:0] CMD_JOY2       = 16'h0010;
	localparam logic [WORD_W-1:0] CMD_JOY3       = 16'h0011;
	localparam logic [WORD_W-1:0] CMD_KBD        = 16'h0005;
	localparam logic [WORD_W-1:0] CMD_STATUS     = 16'h001E;
	localparam logic [WORD_W-1:0] CMD_STATUS_REQ = 16'h0029;

	// file channel commands
	localparam logic [WORD_W-1:0] FIO_FILE_TX     = 16'h0053;
	localparam logic [WORD_W-1:0] FIO_FILE_TX_DAT = 16'h0054;
	localparam logic [WORD_W-1:0] FIO_FILE_INDEX  = 16'h0055;

	////////////////////
	// keyboard byte stream

	localparam logic [7:0] KBD_SKIP_MARK = 8'hFF;
	localparam logic [7:0] KBD_RELEASE   = 8'hF0;
	localparam logic [7:0] KBD_EXT       = 8'hE0;

	// multi-byte sequences and the {pressed, extended, code} they collapse to
	localparam logic [31:0] PRNSCR_DOWN     = 32'hE012E07C;
	localparam logic [9:0]  PRNSCR_DOWN_KEY = 10'h37C;
	localparam logic [31:0] PRNSCR_UP       = 32'h7CE0F012;
	localparam logic [9:0]  PRNSCR_UP_KEY   = 10'h17C;
	localparam logic [31:0] PAUSE_DOWN      = 32'hF014F077;
	localparam logic [9:0]  PAUSE_DOWN_KEY  = 10'h377;

	////////////////////
	// types

	typedef struct packed {
		logic [7:0] mark;
		logic [7:0] code;
	} ps2_word_t;

	// keyboard words carry a mark byte over the scan code byte
	typedef union packed {
		logic [WORD_W-1:0] raw;
		ps2_word_t         ps2;
	} host_data_u;

	typedef struct packed {
		logic              valid;
		logic              chan;
		logic              first;
		logic [WORD_W-1:0] cmd;
		logic [IDX_W-1:0]  idx;
		host_data_u        data;
	} host_word_t;

	typedef struct packed {
		logic user_end;
		logic file_end;
	} frame_end_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	typedef logic [NUM_JOY-1:0][31:0] joy_set_t;

	typedef struct packed {
		logic                download;
		logic                wr;
		logic [15:0]         index;
		logic [IOCTL_AW-1:0] addr;
		logic [15:0]         dout;
	} ioctl_t;

endpackage

// File: design/host_frame.sv
// host bus framing stage
// registers the host word bus, latches the command of each frame,
// numbers the later words and flags the end of every frame

module host_frame (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  logic                            io_strobe,
	input  logic                            io_enable,
	input  logic                            fp_enable,
	input  logic [hps_link_pkg::WORD_W-1:0] io_din,
	output hps_link_pkg::host_word_t        word,
	output hps_link_pkg::frame_end_t        frame_end
);
	import hps_link_pkg::*;

	logic              frame_on;
	logic              take;
	logic              io_en_q;
	logic              fp_en_q;
	logic              has_cmd;
	logic [IDX_W-1:0]  cnt;
	logic              valid_q;
	logic              chan_q;
	logic              first_q;
	logic [IDX_W-1:0]  idx_q;
	logic [WORD_W-1:0] cmd;
	host_data_u        din_q;

	assign frame_on = io_enable | fp_enable;
	assign take     = io_strobe & frame_on;

	// frame state and end detection
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			io_en_q   <= 1'b0;
			fp_en_q   <= 1'b0;
			has_cmd   <= 1'b0;
			cnt       <= '0;
			valid_q   <= 1'b0;
			frame_end <= '0;
		end else begin
			io_en_q            <= io_enable;
			fp_en_q            <= fp_enable;
			frame_end.user_end <= io_en_q & ~io_enable;
			frame_end.file_end <= fp_en_q & ~fp_enable;
			valid_q            <= take;
			if (!frame_on) begin
				has_cmd <= 1'b0;
				cnt     <= '0;
			end else if (io_strobe) begin
				has_cmd <= 1'b1;
				// stick at the top index for long frames
				if (~&cnt)
					cnt <= cnt + 1'b1;
			end
		end
	end

	// word payload latched with each accepted strobe
	always_ff @(posedge clk_sys) begin
		if (take) begin
			chan_q  <= fp_enable;
			first_q <= ~has_cmd;
			idx_q   <= cnt;
			din_q   <= io_din;
			if (!has_cmd)
				cmd <= io_din;
		end
	end

	assign word = '{valid: valid_q, chan: chan_q, first: first_q,
	                cmd: cmd, idx: idx_q, data: din_q};

endmodule

// File: design/user_io_regs.sv
// user-io register decoder
// holds configuration, joystick and status words written by the host,
// captures status-set requests from the core and drives the reply word

module user_io_regs (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	input  hps_link_pkg::host_word_t        word,
	input  hps_link_pkg::frame_end_t        frame_end,
	input  logic [63:0]                     status_in,
	input  logic                            status_set,
	output logic [1:0]                      buttons,
	output logic                            forced_scandoubler,
	output logic                            direct_video,
	output hps_link_pkg::joy_set_t          joystick,
	output logic [63:0]                     status,
	output logic [hps_link_pkg::WORD_W-1:0] io_dout
);
	import hps_link_pkg::*;

	logic              user_word;
	logic              user_data;
	logic [WORD_W-1:0] cfg;
	logic              joy_hit;
	logic [JOY_IW-1:0] joy_idx;
	logic              status_set_q;
	logic              set_edge;
	logic [3:0]        stflg;
	logic [63:0]       status_req;
	logic [WORD_W-1:0] reply;

	assign user_word = word.valid & ~word.chan;
	assign user_data = user_word & ~word.first;

	// config bits used by this core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// joystick commands are not contiguous
	always_comb begin
		joy_hit = 1'b1;
		joy_idx = '0;
		case (word.cmd)
			CMD_JOY0: joy_idx = JOY_IW'(0);
			CMD_JOY1: joy_idx = JOY_IW'(1);
			CMD_JOY2: joy_idx = JOY_IW'(2);
			CMD_JOY3: joy_idx = JOY_IW'(3);
			default:  joy_hit = 1'b0;
		endcase
	end

	////////////////////
	// host writes

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg      <= '0;
			joystick <= '0;
			status   <= '0;
		end else if (user_data) begin
			if (word.cmd == CMD_CFG)
				cfg <= word.data.raw;
			if (joy_hit) begin
				// low half on word 1 and high half on every later word
				if (word.idx == IDX_W'(1))
					joystick[joy_idx][15:0] <= word.data.raw;
				else
					joystick[joy_idx][31:16] <= word.data.raw;
			end
			if (word.cmd == CMD_STATUS) begin
				case (word.idx)
					IDX_W'(1): status[15:0]  <= word.data.raw;
					IDX_W'(2): status[31:16] <= word.data.raw;
					IDX_W'(3): status[47:32] <= word.data.raw;
					IDX_W'(4): status[63:48] <= word.data.raw;
					default: ;
				endcase
			end
		end
	end

	////////////////////
	// status-set request from the core

	assign set_edge = status_set & ~status_set_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			status_set_q <= 1'b0;
			stflg        <= '0;
		end else begin
			status_set_q <= status_set;
			if (set_edge)
				stflg <= stflg + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (set_edge)
			status_req <= status_in;
	end

	////////////////////
	// reply word

	always_comb begin
		reply = '0;
		if (word.cmd == CMD_STATUS_REQ) begin
			if (word.first) begin
				// header lets the host see how many requests were made
				reply = WORD_W'({4'hA, stflg});
			end else begin
				case (word.idx)
					IDX_W'(1): reply = status_req[15:0];
					IDX_W'(2): reply = status_req[31:16];
					IDX_W'(3): reply = status_req[47:32];
					IDX_W'(4): reply = status_req[63:48];
					default:   reply = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			io_dout <= '0;
		else if (frame_end.user_end)
			io_dout <= '0;
		else if (user_word)
			io_dout <= reply;
	end

endmodule

// File: design/ps2_key_decoder.sv
// keyboard byte decoder
// collects the scan code bytes of one keyboard frame and turns them
// into a single key event when the frame closes

module ps2_key_decoder (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  hps_link_pkg::host_word_t word,
	input  hps_link_pkg::frame_end_t frame_end,
	output hps_link_pkg::ps2_key_t   ps2_key
);
	import hps_link_pkg::*;

	logic        kbd_word;
	logic        kbd_frame;
	logic        skip;
	logic [31:0] raw;
	logic        pressed;
	logic        extended;

	assign kbd_word = word.valid & ~word.chan & (word.cmd == CMD_KBD);

	// newest byte sits in raw[7:0]
	assign pressed  = (raw[15:8] != KBD_RELEASE);
	assign extended = pressed ? (raw[15:8] == KBD_EXT) : (raw[23:16] == KBD_EXT);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			kbd_frame <= 1'b0;
			skip      <= 1'b0;
			raw       <= '0;
			ps2_key   <= '0;
		end else if (frame_end.user_end) begin
			if (kbd_frame && !skip) begin
				ps2_key.toggle <= ~ps2_key.toggle;
				case (raw)
					PRNSCR_DOWN:
						{ps2_key.pressed, ps2_key.extended, ps2_key.code} <= PRNSCR_DOWN_KEY;
					PRNSCR_UP:
						{ps2_key.pressed, ps2_key.extended, ps2_key.code} <= PRNSCR_UP_KEY;
					PAUSE_DOWN:
						{ps2_key.pressed, ps2_key.extended, ps2_key.code} <= PAUSE_DOWN_KEY;
					default: begin
						ps2_key.pressed  <= pressed;
						ps2_key.extended <= extended;
						ps2_key.code     <= raw[7:0];
					end
				endcase
			end
			kbd_frame <= 1'b0;
		end else if (kbd_word) begin
			if (word.first) begin
				kbd_frame <= 1'b1;
				skip      <= 1'b0;
				raw       <= '0;
			end else if (word.data.ps2.mark == KBD_SKIP_MARK) begin
				// rest of this frame and its event are dropped
				skip <= 1'b1;
			end else if (!skip) begin
				raw <= {raw[23:0], word.data.ps2.code};
			end
		end
	end

endmodule

// File: design/file_loader.sv
// file channel loader
// takes the file index and download start/stop from the host and turns
// each data word into one ioctl write at a rising byte address

module file_loader (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  hps_link_pkg::host_word_t word,
	output hps_link_pkg::ioctl_t     ioctl
);
	import hps_link_pkg::*;

	logic                file_data;
	logic                first_arg;
	logic [IOCTL_AW-1:0] addr_next;

	// file channel words after the command word
	assign file_data = word.valid & word.chan & ~word.first;
	assign first_arg = (word.idx == IDX_W'(1));

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl     <= '0;
			addr_next <= '0;
		end else begin
			// wr is a single cycle strobe
			ioctl.wr <= 1'b0;
			if (file_data) begin
				case (word.cmd)
					FIO_FILE_INDEX: begin
						if (first_arg)
							ioctl.index <= word.data.raw;
					end

					FIO_FILE_TX: begin
						if (first_arg) begin
							if (|word.data.raw[7:0]) begin
								ioctl.download <= 1'b1;
								addr_next      <= '0;
							end else begin
								// leave addr at the first byte not written
								if (ioctl.download)
									ioctl.addr <= addr_next;
								ioctl.download <= 1'b0;
							end
						end
					end

					FIO_FILE_TX_DAT: begin
						if (ioctl.download) begin
							ioctl.wr   <= 1'b1;
							ioctl.addr <= addr_next;
							ioctl.dout <= word.data.raw;
							addr_next  <= addr_next + IOCTL_AW'(IOCTL_STEP);
						end
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// File: design/hps_link_top.sv
// host link top level
// framing stage feeding the user-io, keyboard and file decode stages

module hps_link_top (
	input  logic                            clk_sys,
	input  logic                            rst_n,
	// host word bus
	input  logic                            io_strobe,
	input  logic                            io_enable,
	input  logic                            fp_enable,
	input  logic [hps_link_pkg::WORD_W-1:0] io_din,
	output logic [hps_link_pkg::WORD_W-1:0] io_dout,
	output logic                            host_wait,
	// core side
	input  logic                            ioctl_wait,
	input  logic [63:0]                     status_in,
	input  logic                            status_set,
	output logic [1:0]                      buttons,
	output logic                            forced_scandoubler,
	output logic                            direct_video,
	output hps_link_pkg::joy_set_t          joystick,
	output logic [63:0]                     status,
	output hps_link_pkg::ps2_key_t          ps2_key,
	output hps_link_pkg::ioctl_t            ioctl
);
	import hps_link_pkg::*;

	host_word_t word;
	frame_end_t frame_end;

	// the core throttles the host directly
	assign host_wait = ioctl_wait;

	////////////////////
	// stage 1

	host_frame u_frame (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_din    (io_din),
		.word      (word),
		.frame_end (frame_end)
	);

	////////////////////
	// stage 2

	user_io_regs u_user (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.word               (word),
		.frame_end          (frame_end),
		.status_in          (status_in),
		.status_set         (status_set),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick           (joystick),
		.status             (status),
		.io_dout            (io_dout)
	);

	ps2_key_decoder u_kbd (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.word      (word),
		.frame_end (frame_end),
		.ps2_key   (ps2_key)
	);

	file_loader u_file (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.word    (word),
		.ioctl   (ioctl)
	);

endmodule

// File: tb/tb_hps_link.sv
// host link testbench
// drives random user-io, keyboard and file frames into the DUT and
// compares every output against a reference model kept here

module tb_hps_link;
	timeunit 1ns;
	timeprecision 100ps;
	import hps_link_pkg::*;

	localparam logic [31:0] SEED = 32'hc5dc6d70;
	localparam int N_CFG  = 20;
	localparam int N_STAT = 8;
	localparam int N_REQ  = 5;
	localparam int N_KBD  = 32;
	localparam int N_DL   = 4;
	// worst case per word is strobe, 7 idle cycles and a held wait
	localparam int WORD_CYC   = 14;
	localparam int FRAME_CYC  = 5;
	localparam int MAX_WORDS  = 5 * (N_CFG + N_STAT + N_REQ + N_KBD) + 23 * N_DL;
	localparam int MAX_FRAMES = N_CFG + N_STAT + N_REQ + N_KBD + 4 * N_DL;
	localparam int MAX_CYCLES = 20 + MAX_WORDS * WORD_CYC + MAX_FRAMES * FRAME_CYC + N_REQ * 6;

	logic              clk_sys;
	logic              rst_n;
	logic              io_strobe;
	logic              io_enable;
	logic              fp_enable;
	logic [WORD_W-1:0] io_din;
	logic [WORD_W-1:0] io_dout;
	logic              host_wait;
	logic              ioctl_wait;
	logic [63:0]       status_in;
	logic              status_set;
	logic [1:0]        buttons;
	logic              forced_scandoubler;
	logic              direct_video;
	joy_set_t          joystick;
	logic [63:0]       status;
	ps2_key_t          ps2_key;
	ioctl_t            ioctl;

	// reference model state
	logic [31:0]         lfsr;
	logic [15:0]         exp_cfg;
	joy_set_t            exp_joy;
	logic [63:0]         exp_status;
	logic [3:0]          exp_stflg;
	logic [63:0]         exp_req;
	ps2_key_t            exp_key;
	logic [15:0]         exp_index;
	logic [IOCTL_AW-1:0] wr_addr_q[$];
	logic [15:0]         wr_data_q[$];

	hps_link_top i_dut (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.host_wait          (host_wait),
		.ioctl_wait         (ioctl_wait),
		.status_in          (status_in),
		.status_set         (status_set),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick           (joystick),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl              (ioctl)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (2 * MAX_CYCLES) @(posedge clk_sys);
		$display("*** FAILED ***");
		$fatal(1, "timeout, the tests did not finish within %0d cycles", 2 * MAX_CYCLES);
	end

	// collect ioctl writes away from the clock edge
	always @(negedge clk_sys) begin
		if (ioctl.wr) begin
			wr_addr_q.push_back(ioctl.addr);
			wr_data_q.push_back(ioctl.dout);
		end
	end

	////////////////////
	// helpers

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		// taps 32, 22, 2, 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic coin();
		logic [63:0] v;
		v = rand_bits(1);
		return v[0];
	endfunction

	function automatic logic [15:0] joy_cmd(logic [1:0] j);
		case (j)
			2'd0:    return CMD_JOY0;
			2'd1:    return CMD_JOY1;
			2'd2:    return CMD_JOY2;
			default: return CMD_JOY3;
		endcase
	endfunction

	task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic open_frame(logic fp);
		if (fp)
			fp_enable <= 1'b1;
		else
			io_enable <= 1'b1;
		@(posedge clk_sys);
	endtask

	task automatic close_frame();
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	// one strobe, then 4 to 7 idle cycles
	task automatic send_word(logic [15:0] data);
		int gap;
		gap = 4 + int'(rand_bits(2));
		while (host_wait)
			@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din    <= data;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		repeat (gap) @(posedge clk_sys);
	endtask

	////////////////////
	// tests

	task automatic drive_cfg_joy();
		logic [15:0] val;
		logic [1:0]  j;
		int          t;
		int          k;
		int          n;
		for (t = 0; t < N_CFG; t++) begin
			open_frame(1'b0);
			if (coin()) begin
				val = 16'(rand_bits(16));
				send_word(CMD_CFG);
				send_word(val);
				exp_cfg = val;
			end else begin
				j = 2'(rand_bits(2));
				n = 1 + int'(rand_bits(2));
				send_word(joy_cmd(j));
				for (k = 1; k <= n; k++) begin
					val = 16'(rand_bits(16));
					send_word(val);
					// word 1 is the low half, the rest land in the high half
					if (k == 1)
						exp_joy[j][15:0] = val;
					else
						exp_joy[j][31:16] = val;
				end
			end
			close_frame();
			check_value("buttons", 64'(exp_cfg[1:0]), 64'(buttons));
			check_value("forced_scandoubler", 64'(exp_cfg[4]), 64'(forced_scandoubler));
			check_value("direct_video", 64'(exp_cfg[10]), 64'(direct_video));
			check_value("joystick 0", 64'(exp_joy[0]), 64'(joystick[0]));
			check_value("joystick 1", 64'(exp_joy[1]), 64'(joystick[1]));
			check_value("joystick 2", 64'(exp_joy[2]), 64'(joystick[2]));
			check_value("joystick 3", 64'(exp_joy[3]), 64'(joystick[3]));
		end
	endtask

	task automatic drive_status();
		logic [63:0] val;
		int          t;
		for (t = 0; t < N_STAT; t++) begin
			val = rand_bits(64);
			open_frame(1'b0);
			send_word(CMD_STATUS);
			send_word(val[15:0]);
			send_word(val[31:16]);
			send_word(val[47:32]);
			send_word(val[63:48]);
			close_frame();
			exp_status = val;
			check_value("status", exp_status, status);
		end
	endtask

	task automatic read_status_req();
		logic [63:0] val;
		int          t;
		int          k;
		int          n;
		for (t = 0; t < N_REQ; t++) begin
			n = 1 + int'(rand_bits(1));
			for (k = 0; k < n; k++) begin
				val = rand_bits(64);
				status_in  <= val;
				status_set <= 1'b1;
				@(posedge clk_sys);
				status_set <= 1'b0;
				repeat (2) @(posedge clk_sys);
				exp_req   = val;
				exp_stflg = exp_stflg + 4'd1;
			end
			open_frame(1'b0);
			send_word(CMD_STATUS_REQ);
			check_value("status_req header", 64'({8'h00, 4'hA, exp_stflg}), 64'(io_dout));
			for (k = 1; k <= 4; k++) begin
				send_word(16'(rand_bits(16)));
				check_value("status_req quarter", 64'(16'(exp_req >> (16 * (k - 1)))),
					64'(io_dout));
			end
			close_frame();
			check_value("io_dout after frame", 64'd0, 64'(io_dout));
		end
	endtask

	task automatic type_keys();
		logic [7:0]  bytes[$];
		logic [7:0]  code;
		logic [31:0] seq;
		logic [9:0]  key;
		logic        skip;
		int          t;
		int          i;
		int          kind;
		for (t = 0; t < N_KBD; t++) begin
			bytes.delete();
			kind = int'(rand_bits(3));
			code = 8'(rand_bits(8));
			skip = 1'b0;
			seq  = '0;
			key  = '0;
			// key is {pressed, extended, code}
			case (kind)
				0: begin
					bytes.push_back(code);
					key = {2'b10, code};
				end
				1: begin
					bytes.push_back(KBD_RELEASE);
					bytes.push_back(code);
					key = {2'b00, code};
				end
				2: begin
					bytes.push_back(KBD_EXT);
					bytes.push_back(code);
					key = {2'b11, code};
				end
				3: begin
					bytes.push_back(KBD_EXT);
					bytes.push_back(KBD_RELEASE);
					bytes.push_back(code);
					key = {2'b01, code};
				end
				4: begin
					seq = PRNSCR_DOWN;
					key = PRNSCR_DOWN_KEY;
				end
				5: begin
					seq = PRNSCR_UP;
					key = PRNSCR_UP_KEY;
				end
				6: begin
					seq = PAUSE_DOWN;
					key = PAUSE_DOWN_KEY;
				end
				default: begin
					bytes.push_back(code);
					skip = 1'b1;
				end
			endcase
			if (kind >= 4 && kind <= 6) begin
				for (i = 0; i < 4; i++)
					bytes.push_back(8'(seq >> (24 - 8 * i)));
			end
			open_frame(1'b0);
			send_word(CMD_KBD);
			for (i = 0; i < bytes.size(); i++)
				send_word({8'h00, bytes[i]});
			if (skip) begin
				send_word({KBD_SKIP_MARK, 8'(rand_bits(8))});
				send_word({8'h00, 8'(rand_bits(8))});
			end
			close_frame();
			// a skipped frame leaves the key untouched
			if (!skip) begin
				exp_key.toggle = ~exp_key.toggle;
				{exp_key.pressed, exp_key.extended, exp_key.code} = key;
			end
			check_value("ps2_key", 64'(exp_key), 64'(ps2_key));
		end
	endtask

	task automatic download_files();
		logic [15:0] sent[$];
		logic [15:0] val;
		int          t;
		int          k;
		int          n;
		int          base;
		for (t = 0; t < N_DL; t++) begin
			sent.delete();
			val = 16'(rand_bits(16));
			open_frame(1'b1);
			send_word(FIO_FILE_INDEX);
			send_word(val);
			close_frame();
			exp_index = val;
			check_value("ioctl index", 64'(exp_index), 64'(ioctl.index));

			open_frame(1'b1);
			send_word(FIO_FILE_TX);
			send_word({8'(rand_bits(8)), 8'(rand_bits(8)) | 8'h01});
			close_frame();
			check_value("download start", 64'd1, 64'(ioctl.download));

			n    = 1 + int'(rand_bits(4));
			base = wr_addr_q.size();
			open_frame(1'b1);
			send_word(FIO_FILE_TX_DAT);
			for (k = 0; k < n; k++) begin
				if (coin()) begin
					ioctl_wait <= 1'b1;
					repeat (1 + int'(rand_bits(2))) @(posedge clk_sys);
					check_value("host_wait", 64'd1, 64'(host_wait));
					ioctl_wait <= 1'b0;
				end
				val = 16'(rand_bits(16));
				sent.push_back(val);
				send_word(val);
			end
			close_frame();

			open_frame(1'b1);
			send_word(FIO_FILE_TX);
			send_word({8'(rand_bits(8)), 8'h00});
			close_frame();
			check_value("download stop", 64'd0, 64'(ioctl.download));
			check_value("addr after stop", 64'(IOCTL_STEP * n), 64'(ioctl.addr));
			check_value("ioctl index kept", 64'(exp_index), 64'(ioctl.index));
			check_value("write count", 64'(n), 64'(wr_addr_q.size() - base));
			for (k = 0; k < n; k++) begin
				check_value("write addr", 64'(IOCTL_STEP * k), 64'(wr_addr_q[base + k]));
				check_value("write data", 64'(sent[k]), 64'(wr_data_q[base + k]));
			end
		end
	endtask

	////////////////////
	// main sequence

	initial begin
		lfsr       = SEED;
		exp_cfg    = '0;
		exp_joy    = '0;
		exp_status = '0;
		exp_stflg  = '0;
		exp_req    = '0;
		exp_key    = '0;
		exp_index  = '0;
		rst_n      <= 1'b0;
		io_strobe  <= 1'b0;
		io_enable  <= 1'b0;
		fp_enable  <= 1'b0;
		io_din     <= '0;
		ioctl_wait <= 1'b0;
		status_in  <= '0;
		status_set <= 1'b0;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);
		check_value("reset io_dout", 64'd0, 64'(io_dout));
		check_value("reset ps2_key", 64'd0, 64'(ps2_key));
		check_value("reset ioctl", 64'd0, 64'(ioctl));
		drive_cfg_joy();
		drive_status();
		read_status_req();
		type_keys();
		download_files();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: sources.f
design/hps_link_pkg.sv
design/host_frame.sv
design/user_io_regs.sv
design/ps2_key_decoder.sv
design/file_loader.sv
design/hps_link_top.sv
tb/tb_hps_link.sv

// File: Makefile
# Verilator build and run of the host link testbench
# the simulator exits with a failing status on any $fatal

VERILATOR ?= verilator
TOP       ?= tb_hps_link
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
